// File: bench/uart_bridge_props.sv
`timescale 1ns/1ps

module uart_bridge_props (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx_start,
  input logic tx_busy,
  input logic read_rdy
);

  int fail_count = 0;

  read_rdy_single: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
  else
  begin
    fail_count++;
    $error("read_rdy stayed high for two cycles");
  end

  tx_start_when_free: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(tx_start) |-> !tx_busy)
  else
  begin
    fail_count++;
    $error("tx_start rose while the serializer was busy");
  end

  // An accepted command takes the FSM out of idle straight away
  accept_leaves_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cmd_rdy)
  else
  begin
    fail_count++;
    $error("cmd_rdy high in the cycle after acceptance");
  end

endmodule

bind bridge_cmd_controller uart_bridge_props u_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx_start (tx_start),
  .tx_busy  (tx_busy),
  .read_rdy (read_rdy)
);

// File: bench/uart_bridge_tb.sv
`timescale 1ns/1ps

module uart_bridge_tb;

  import uart_frame_pkg::*;
  import bridge_cmd_pkg::*;

  localparam int CLKS_PER_BIT       = 8;
  localparam int GAP_BITS           = 2;
  localparam int REPLY_TIMEOUT_BITS = 32;
  localparam int SEED               = 14;
  localparam int NUM_TESTS          = 6;
  localparam int CMDS_PER_TEST      = 8;
  localparam int WRITE_CYCLES       = (2 * FRAME_SLOTS + GAP_BITS) * CLKS_PER_BIT + 3;
  localparam int CMD_MAX_CYCLES     =
    (2 * FRAME_SLOTS + GAP_BITS + REPLY_TIMEOUT_BITS) * CLKS_PER_BIT + 16;
  localparam int WATCHDOG_CYCLES    = CMD_MAX_CYCLES * CMDS_PER_TEST * NUM_TESTS * 2;

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  rx;
  logic                  tx;
  logic                  read_rdy;
  logic [READ_WIDTH-1:0] read_data;
  logic                  read_err;
  logic                  corrupt_parity;
  logic                  break_stop;
  logic                  silent;

  logic [7:0] shadow [0:127];
  int         check_count = 0;
  int         mismatch_count = 0;
  int         timeout_count = 0;

  uart_bridge #(
    .CLKS_PER_BIT      (CLKS_PER_BIT),
    .GAP_BITS          (GAP_BITS),
    .REPLY_TIMEOUT_BITS(REPLY_TIMEOUT_BITS)
  ) UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .rx       (rx),
    .tx       (tx),
    .read_rdy (read_rdy),
    .read_data(read_data),
    .read_err (read_err)
  );

  uart_remote_model #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) remote (
    .clk           (clk),
    .rst_n         (rst_n),
    .tx            (tx),
    .rx            (rx),
    .corrupt_parity(corrupt_parity),
    .break_stop    (break_stop),
    .silent        (silent)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  // Inputs change and outputs are read 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    check_count++;
    if (got !== exp)
    begin
      mismatch_count++;
      $display("FAIL time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
    end
  endtask

  function automatic logic [6:0] rand_addr();
    return 7'($urandom());
  endfunction

  function automatic logic [7:0] rand_data();
    return 8'($urandom());
  endfunction

  task automatic issue_cmd(input logic [15:0] cmd, input bit keep_vld, output bit accepted);
    int n;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    n = 0;
    while (!cmd_rdy && n < CMD_MAX_CYCLES)
    begin
      step();
      n++;
    end
    accepted = cmd_rdy;
    if (accepted)
    begin
      step();
    end
    else
    begin
      timeout_count++;
      $display("Timeout: command %h was not accepted within %0d cycles", cmd, n);
    end
    if (!keep_vld)
    begin
      cmd_vld = 1'b0;
    end
  endtask

  task automatic wait_idle(output int cycles);
    cycles = 0;
    while (!cmd_rdy && cycles < CMD_MAX_CYCLES)
    begin
      step();
      cycles++;
    end
    if (!cmd_rdy)
    begin
      timeout_count++;
      $display("Timeout: cmd_rdy stayed low for %0d cycles", cycles);
    end
  endtask

  task automatic do_write(input logic [6:0] addr, input logic [7:0] data, output int cycles);
    bit accepted;
    cycles = 0;
    issue_cmd({1'b1, addr, data}, 1'b0, accepted);
    if (accepted)
    begin
      wait_idle(cycles);
      shadow[addr] = data;
    end
  endtask

  task automatic do_read(input logic [6:0] addr, output logic [7:0] data, output logic err);
    bit accepted;
    int n;
    data = 'x;
    err  = 1'bx;
    issue_cmd({1'b0, addr, 8'h00}, 1'b0, accepted);
    n = 0;
    while (accepted && !read_rdy && n < CMD_MAX_CYCLES)
    begin
      step();
      n++;
    end
    if (accepted && read_rdy)
    begin
      data = read_data;
      err  = read_err;
    end
    else if (accepted)
    begin
      timeout_count++;
      $display("Timeout: read_rdy did not pulse within %0d cycles of reading %h", n, addr);
    end
  endtask

  task automatic test_reset_state();
    check_value("tx", tx, 1'b1);
    check_value("cmd_rdy", cmd_rdy, 1'b1);
    check_value("read_rdy", read_rdy, 1'b0);
  endtask

  task automatic test_write_read();
    logic [6:0] addrs [4];
    logic [7:0] data;
    logic       err;
    int         cycles;
    int         i;
    for (i = 0; i < 4; i++)
    begin
      addrs[i] = rand_addr();
      do_write(addrs[i], rand_data(), cycles);
    end
    for (i = 0; i < 4; i++)
    begin
      do_read(addrs[i], data, err);
      check_value("read_data", data, shadow[addrs[i]]);
      check_value("read_err", err, 1'b0);
    end
  endtask

  task automatic test_write_frame();
    logic [15:0] cmd;
    int          base;
    int          cycles;
    base = remote.frame_count;
    cmd  = {1'b1, rand_addr(), rand_data()};
    do_write(cmd[14:8], cmd[7:0], cycles);
    check_value("frame_count", 16'(remote.frame_count - base), 16'd2);
    check_value("addr_frame", remote.frame_log[base], cmd[15:8]);
    check_value("data_frame", remote.frame_log[base + 1], cmd[7:0]);
    check_value("write_cycles", 16'(cycles), 16'(WRITE_CYCLES));
  endtask

  task automatic test_faulty_reply();
    logic [6:0] addr;
    logic [7:0] data;
    logic       err;
    int         cycles;
    addr = rand_addr();
    do_write(addr, rand_data(), cycles);
    corrupt_parity = 1'b1;
    do_read(addr, data, err);
    corrupt_parity = 1'b0;
    check_value("read_err", err, 1'b1);
    break_stop = 1'b1;
    do_read(addr, data, err);
    break_stop = 1'b0;
    check_value("read_err", err, 1'b1);
    do_read(addr, data, err);
    check_value("read_data", data, shadow[addr]);
    check_value("read_err", err, 1'b0);
  endtask

  task automatic test_no_reply();
    logic [6:0] addr;
    logic [7:0] data;
    logic       err;
    int         cycles;
    silent = 1'b1;
    do_read(rand_addr(), data, err);
    silent = 1'b0;
    check_value("read_err", err, 1'b1);
    check_value("read_data", data, 8'h00);
    addr = rand_addr();
    do_write(addr, rand_data(), cycles);
    do_read(addr, data, err);
    check_value("read_data", data, shadow[addr]);
    check_value("read_err", err, 1'b0);
  endtask

  task automatic test_back_pressure();
    logic [15:0] cmds [4];
    int          base;
    int          cycles;
    bit          accepted;
    int          i;
    base = remote.frame_count;
    // cmd_vld stays high from the first command to the last
    for (i = 0; i < 4; i++)
    begin
      cmds[i] = {1'b1, rand_addr(), rand_data()};
      issue_cmd(cmds[i], 1'b1, accepted);
    end
    cmd_vld = 1'b0;
    wait_idle(cycles);
    check_value("frame_count", 16'(remote.frame_count - base), 16'd8);
    for (i = 0; i < 4; i++)
    begin
      check_value("addr_frame", remote.frame_log[base + 2 * i], cmds[i][15:8]);
      check_value("data_frame", remote.frame_log[base + 2 * i + 1], cmds[i][7:0]);
      shadow[cmds[i][14:8]] = cmds[i][7:0];
    end
  endtask

  initial
  begin
    void'($urandom(SEED));
    rst_n          = 1'b0;
    cmd_in         = '0;
    cmd_vld        = 1'b0;
    corrupt_parity = 1'b0;
    break_stop     = 1'b0;
    silent         = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step();
    test_reset_state();
    test_write_read();
    test_write_frame();
    test_faulty_reply();
    test_no_reply();
    test_back_pressure();
    check_value("model_frame_errors", 16'(remote.frame_errors), 16'd0);
    $display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
             check_count, mismatch_count, timeout_count, UUT.u_ctrl.u_props.fail_count);
    if (mismatch_count == 0 && timeout_count == 0 && UUT.u_ctrl.u_props.fail_count == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: bench/uart_remote_model.sv
`timescale 1ns/1ps

module uart_remote_model #(
  parameter int CLKS_PER_BIT     = 8,
  parameter int REPLY_DELAY_BITS = 3
) (
  input  logic clk,
  input  logic rst_n,
  input  logic tx,
  output logic rx,
  input  logic corrupt_parity,
  input  logic break_stop,
  input  logic silent
);

  logic [7:0] regs [0:127];
  logic [7:0] frame_log [0:255];
  int         frame_count = 0;
  int         frame_errors = 0;

  // Samples the bridge's tx line at slot centres, on the falling clock edge
  task automatic receive_frame(output logic [7:0] data);
    logic [7:0] bits;
    logic       parity;
    int         i;
    @(negedge tx);
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    if (tx !== 1'b0)
    begin
      frame_errors++;
    end
    for (i = 0; i < 8; i++)
    begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      bits[i] = tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    parity = tx;
    repeat (CLKS_PER_BIT) @(negedge clk);
    if (tx !== 1'b1 || parity !== ^bits)
    begin
      frame_errors++;
    end
    if (frame_count < 256)
    begin
      frame_log[frame_count] = bits;
    end
    frame_count++;
    data = bits;
  endtask

  // Start, data LSB first, even parity, stop, with the requested faults
  task automatic send_frame(input logic [7:0] data);
    logic [10:0] bits;
    int          i;
    bits = {~break_stop, (^data) ^ corrupt_parity, data, 1'b0};
    for (i = 0; i < 11; i++)
    begin
      @(posedge clk);
      #1;
      rx = bits[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
    @(posedge clk);
    #1;
    rx = 1'b1;
  endtask

  initial
  begin : serve
    logic [7:0] head;
    logic [7:0] data;
    int         i;
    rx = 1'b1;
    // Every address gets its own start value
    for (i = 0; i < 128; i++)
    begin
      regs[i] = 8'(i * 29) ^ 8'h5a;
    end
    wait (rst_n === 1'b1);
    forever
    begin
      receive_frame(head);
      if (head[7])
      begin
        receive_frame(data);
        regs[head[6:0]] = data;
      end
      else if (!silent)
      begin
        repeat (REPLY_DELAY_BITS * CLKS_PER_BIT) @(posedge clk);
        send_frame(regs[head[6:0]]);
      end
    end
  end

endmodule

// File: source/bridge_cmd_controller.sv
`timescale 1ns/1ps

module bridge_cmd_controller #(
  parameter int CLKS_PER_BIT       = 434,
  parameter int GAP_BITS           = 2,
  parameter int REPLY_TIMEOUT_BITS = 32
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [bridge_cmd_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                                  cmd_vld,
  output logic                                  cmd_rdy,
  output logic [uart_frame_pkg::DATA_BITS-1:0]  tx_byte,
  output logic                                  tx_start,
  input  logic                                  tx_busy,
  output logic                                  rx_listen,
  input  logic [uart_frame_pkg::DATA_BITS-1:0]  rx_byte,
  input  uart_frame_pkg::rx_status_t            rx_status,
  input  logic                                  rx_done,
  output logic                                  read_rdy,
  output logic [bridge_cmd_pkg::READ_WIDTH-1:0] read_data,
  output logic                                  read_err
);

  import uart_frame_pkg::*;
  import bridge_cmd_pkg::*;

  // Two cycles of the gap are spent in the handshake with the serializer
  localparam int GAP_LAST     = GAP_BITS * CLKS_PER_BIT - 2;
  localparam int TIMEOUT_LAST = REPLY_TIMEOUT_BITS * CLKS_PER_BIT - 2;
  localparam int WAIT_MAX     = (GAP_LAST > TIMEOUT_LAST) ? GAP_LAST : TIMEOUT_LAST;
  localparam int WAIT_W       = $clog2(WAIT_MAX + 2);

  typedef enum logic [2:0] {
    idle,
    send_addr,
    gap,
    send_data,
    await_reply,
    respond
  } state_t;

  state_t               state;
  logic [CMD_WIDTH-1:0] cmd_q;
  logic [WAIT_W-1:0]    wait_cnt;
  cmd_op_t              op;
  logic                 accept;
  logic                 tx_done;
  logic                 gap_over;
  logic                 reply_timeout;

  assign cmd_rdy   = (state == idle);
  assign accept    = cmd_vld && cmd_rdy;
  assign rx_listen = (state == await_reply);
  assign read_rdy  = (state == respond);

  assign op = cmd_op_t'(cmd_q[OP_BIT]);

  // First frame carries op and address, the second the write data
  assign tx_byte = (state == send_data) ? cmd_q[WDATA_WIDTH-1:0]
                                        : {cmd_q[OP_BIT], cmd_q[OP_BIT-1 -: ADDR_WIDTH]};

  // The serializer only raises busy the cycle after the start pulse
  assign tx_done = !tx_start && !tx_busy;

  assign gap_over      = (wait_cnt == WAIT_W'(GAP_LAST));
  assign reply_timeout = (state == await_reply) && (wait_cnt == WAIT_W'(TIMEOUT_LAST));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= idle;
      tx_start <= 1'b0;
      wait_cnt <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        idle:
        begin
          if (accept)
          begin
            state    <= send_addr;
            tx_start <= 1'b1;
          end
        end
        send_addr:
        begin
          if (tx_done)
          begin
            wait_cnt <= '0;
            state    <= (op == op_write) ? gap : await_reply;
          end
        end
        gap:
        begin
          if (gap_over)
          begin
            state    <= send_data;
            tx_start <= 1'b1;
          end
          else
          begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        send_data:
        begin
          if (tx_done)
          begin
            state <= idle;
          end
        end
        await_reply:
        begin
          if (rx_done || reply_timeout)
          begin
            state <= respond;
          end
          else
          begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        respond:
        begin
          state <= idle;
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q <= cmd_in;
    end
  end

  // A reply that arrives wins over a timeout in the same cycle
  always_ff @(posedge clk)
  begin
    if (state == await_reply)
    begin
      if (rx_done)
      begin
        read_data <= rx_byte;
        read_err  <= (rx_status != rx_ok);
      end
      else if (reply_timeout)
      begin
        read_data <= '0;
        read_err  <= 1'b1;
      end
    end
  end

endmodule

// File: source/bridge_cmd_pkg.sv
package bridge_cmd_pkg;

  // Host command word and read response widths
  localparam int CMD_WIDTH  = 16;
  localparam int READ_WIDTH = 8;

  // Layout of the command word
  localparam int OP_BIT      = 15;
  localparam int ADDR_WIDTH  = 7;
  localparam int WDATA_WIDTH = 8;

  // Value of the op bit
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } cmd_op_t;

endpackage

// File: source/uart_bridge.sv
`timescale 1ns/1ps

module uart_bridge #(
  parameter int CLKS_PER_BIT       = 434,
  parameter int GAP_BITS           = 2,
  parameter int REPLY_TIMEOUT_BITS = 32
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [bridge_cmd_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                                  cmd_vld,
  output logic                                  cmd_rdy,
  input  logic                                  rx,
  output logic                                  tx,
  output logic                                  read_rdy,
  output logic [bridge_cmd_pkg::READ_WIDTH-1:0] read_data,
  output logic                                  read_err
);

  import uart_frame_pkg::*;

  logic [DATA_BITS-1:0] tx_byte;
  logic                 tx_start;
  logic                 tx_busy;
  logic                 rx_listen;
  logic [DATA_BITS-1:0] rx_byte;
  rx_status_t           rx_status;
  logic                 rx_done;

  uart_tx_serializer #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_byte (tx_byte),
    .tx_start(tx_start),
    .tx      (tx),
    .tx_busy (tx_busy)
  );

  uart_rx_deserializer #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_listen(rx_listen),
    .rx_byte  (rx_byte),
    .rx_status(rx_status),
    .rx_done  (rx_done)
  );

  bridge_cmd_controller #(
    .CLKS_PER_BIT      (CLKS_PER_BIT),
    .GAP_BITS          (GAP_BITS),
    .REPLY_TIMEOUT_BITS(REPLY_TIMEOUT_BITS)
  ) u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .rx_listen(rx_listen),
    .rx_byte  (rx_byte),
    .rx_status(rx_status),
    .rx_done  (rx_done),
    .read_rdy (read_rdy),
    .read_data(read_data),
    .read_err (read_err)
  );

endmodule

// File: source/uart_frame_pkg.sv
package uart_frame_pkg;

  // Payload bits carried by one serial frame
  localparam int DATA_BITS = 8;

  // Start, data, parity and stop slots together
  localparam int FRAME_SLOTS = 11;

  // Slot positions inside a frame, counted from the start bit
  localparam int START_SLOT  = 0;
  localparam int PARITY_SLOT = DATA_BITS + 1;
  localparam int STOP_SLOT   = FRAME_SLOTS - 1;

  // Outcome of one received frame
  typedef enum logic [1:0] {
    rx_ok         = 2'd0,
    rx_parity_err = 2'd1,
    rx_stop_err   = 2'd2
  } rx_status_t;

endpackage

// File: source/uart_rx_deserializer.sv
`timescale 1ns/1ps

module uart_rx_deserializer #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 rx,
  input  logic                                 rx_listen,
  output logic [uart_frame_pkg::DATA_BITS-1:0] rx_byte,
  output uart_frame_pkg::rx_status_t           rx_status,
  output logic                                 rx_done
);

  import uart_frame_pkg::*;

  localparam int CNT_W    = $clog2(CLKS_PER_BIT + 1);
  localparam int SLOT_W   = $clog2(FRAME_SLOTS + 1);
  localparam int HALF_BIT = CLKS_PER_BIT / 2;

  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic                 active;
  logic [CNT_W-1:0]     cnt;
  logic [SLOT_W-1:0]    slot;
  logic [DATA_BITS-1:0] data_q;
  logic                 parity_q;
  logic                 start_edge;
  logic                 sample_now;
  logic                 in_data;

  // Line rests high, so the synchronizer comes out of reset high as well
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_listen && rx_prev && !rx_sync;

  // The start bit is checked half a bit in, every later slot a full bit on
  assign sample_now = active &&
                      (cnt == ((slot == SLOT_W'(START_SLOT)) ? CNT_W'(HALF_BIT - 1)
                                                             : CNT_W'(CLKS_PER_BIT - 1)));

  assign in_data = (slot > SLOT_W'(START_SLOT)) && (slot < SLOT_W'(PARITY_SLOT));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active  <= 1'b0;
      cnt     <= '0;
      slot    <= '0;
      rx_done <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (!active)
      begin
        if (start_edge)
        begin
          active <= 1'b1;
          cnt    <= '0;
          slot   <= SLOT_W'(START_SLOT);
        end
      end
      else if (!rx_listen)
      begin
        active <= 1'b0;
      end
      else if (sample_now)
      begin
        cnt  <= '0;
        slot <= slot + 1'b1;
        // A start bit that has gone high again was only a glitch
        if (slot == SLOT_W'(START_SLOT) && rx_sync)
        begin
          active <= 1'b0;
        end
        if (slot == SLOT_W'(STOP_SLOT))
        begin
          active  <= 1'b0;
          rx_done <= 1'b1;
        end
      end
      else
      begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample_now)
    begin
      if (in_data)
      begin
        data_q <= {rx_sync, data_q[DATA_BITS-1:1]};
      end
      if (slot == SLOT_W'(PARITY_SLOT))
      begin
        parity_q <= rx_sync;
      end
      if (slot == SLOT_W'(STOP_SLOT))
      begin
        rx_byte <= data_q;
        if (!rx_sync)
        begin
          rx_status <= rx_stop_err;
        end
        else if ((^data_q) != parity_q)
        begin
          rx_status <= rx_parity_err;
        end
        else
        begin
          rx_status <= rx_ok;
        end
      end
    end
  end

endmodule

// File: source/uart_tx_serializer.sv
`timescale 1ns/1ps

module uart_tx_serializer #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [uart_frame_pkg::DATA_BITS-1:0] tx_byte,
  input  logic                                 tx_start,
  output logic                                 tx,
  output logic                                 tx_busy
);

  import uart_frame_pkg::*;

  localparam int CNT_W  = $clog2(CLKS_PER_BIT + 1);
  localparam int SLOT_W = $clog2(FRAME_SLOTS + 1);

  logic [FRAME_SLOTS-1:0] frame_q;
  logic [CNT_W-1:0]       bit_cnt;
  logic [SLOT_W-1:0]      slot_cnt;
  logic                   parity;
  logic                   bit_end;

  // Even parity over the data bits
  assign parity = ^tx_byte;

  // The line always shows the lowest bit of the frame register
  assign tx = frame_q[0];

  assign bit_end = (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_q  <= '1;
      bit_cnt  <= '0;
      slot_cnt <= '0;
      tx_busy  <= 1'b0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        // Stop, parity, data LSB first, start
        frame_q  <= {1'b1, parity, tx_byte, 1'b0};
        bit_cnt  <= '0;
        slot_cnt <= SLOT_W'(START_SLOT);
        tx_busy  <= 1'b1;
      end
    end
    else if (bit_end)
    begin
      bit_cnt <= '0;
      // Ones shift in behind the frame so the line rests high afterwards
      frame_q <= {1'b1, frame_q[FRAME_SLOTS-1:1]};
      if (slot_cnt == SLOT_W'(STOP_SLOT))
      begin
        tx_busy <= 1'b0;
      end
      else
      begin
        slot_cnt <= slot_cnt + 1'b1;
      end
    end
    else
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

endmodule

// File: uart_bridge.f
source/uart_frame_pkg.sv
source/bridge_cmd_pkg.sv
source/uart_tx_serializer.sv
source/uart_rx_deserializer.sv
source/bridge_cmd_controller.sv
source/uart_bridge.sv
bench/uart_remote_model.sv
bench/uart_bridge_props.sv
bench/uart_bridge_tb.sv
